//--- fetch_csr.sv
`timescale 1ns/1ps

module fetch_csr import ifetch_pkg::*; (
    input  logic        clk_i,
    input  logic        rst_i,
    input  logic        cfg_we_i,
    input  csr_addr_t   cfg_addr_i,
    input  logic [31:0] cfg_wdata_i,
    output logic [31:0] cfg_rdata_o,
    input  logic        hit_evt_i,
    input  logic        miss_evt_i,
    output logic        fetch_en_o,
    output logic        restart_o,
    output inst_addr_t  start_pc_o,
    output logic        flush_o
);

    logic       en_q;
    logic       restart_q;
    logic       flush_q;
    inst_addr_t start_pc_q;
    cnt_t       hits_q;
    cnt_t       misses_q;
    logic       wr_ctrl;
    logic       wr_start;
    logic       wr_hits;
    logic       wr_misses;

    assign wr_ctrl   = cfg_we_i && (cfg_addr_i == CSR_CTRL);
    assign wr_start  = cfg_we_i && (cfg_addr_i == CSR_START);
    assign wr_hits   = cfg_we_i && (cfg_addr_i == CSR_HITS);
    assign wr_misses = cfg_we_i && (cfg_addr_i == CSR_MISSES);

    assign fetch_en_o = en_q;
    assign restart_o  = restart_q;
    assign start_pc_o = start_pc_q;
    assign flush_o    = flush_q;

    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            en_q       <= 1'b0;
            restart_q  <= 1'b0;
            flush_q    <= 1'b0;
            start_pc_q <= '0;
        end else begin
            // Bit 0 is enable, bit 1 requests a one-cycle flush
            if (wr_ctrl) begin
                en_q <= cfg_wdata_i[0];
            end
            flush_q   <= wr_ctrl && cfg_wdata_i[1];
            restart_q <= wr_start;
            if (wr_start) begin
                start_pc_q <= inst_addr_t'(cfg_wdata_i);
            end
        end
    end

    // Any write to a counter clears it
    always_ff @(posedge clk_i) begin
        if (rst_i || wr_hits) begin
            hits_q <= '0;
        end else if (hit_evt_i) begin
            hits_q <= hits_q + 1'b1;
        end
    end

    always_ff @(posedge clk_i) begin
        if (rst_i || wr_misses) begin
            misses_q <= '0;
        end else if (miss_evt_i) begin
            misses_q <= misses_q + 1'b1;
        end
    end

    always_comb begin
        case (cfg_addr_i)
            CSR_CTRL:   cfg_rdata_o = {31'b0, en_q};
            CSR_START:  cfg_rdata_o = 32'(start_pc_q);
            CSR_HITS:   cfg_rdata_o = hits_q;
            CSR_MISSES: cfg_rdata_o = misses_q;
            default:    cfg_rdata_o = '0;
        endcase
    end

endmodule

//--- fetch_ctrl.sv
`timescale 1ns/1ps

module fetch_ctrl import ifetch_pkg::*; (
    input  logic       clk_i,
    input  logic       rst_i,
    input  logic       fetch_en_i,
    input  logic       restart_i,
    input  inst_addr_t start_pc_i,
    input  logic       cache_hit_i,
    input  inst_t      cache_inst_i,
    output inst_addr_t lookup_pc_o,
    output logic       fill_we_o,
    output inst_addr_t fill_pc_o,
    output inst_t      fill_inst_o,
    output logic       mem_req_o,
    output inst_addr_t mem_addr_o,
    input  logic       mem_credit_i,
    input  logic       mem_rvalid_i,
    input  inst_t      mem_rdata_i,
    input  logic       out_credit_i,
    output logic       inst_valid_o,
    output inst_t      inst_o,
    output inst_addr_t inst_pc_o,
    output logic       hit_evt_o,
    output logic       miss_evt_o
);

    fetch_state_t          state_q;
    fetch_state_t          state_d;
    inst_addr_t            pc_q;
    logic [OUT_CNT_W-1:0]  out_cnt_q;
    logic [MEM_CNT_W-1:0]  mem_cnt_q;
    logic                  pending_q;
    logic                  refill_q;
    logic                  deliver;
    logic                  miss;

    // The current address drives lookup, request and fill alike
    assign lookup_pc_o = pc_q;
    assign mem_addr_o  = pc_q;
    assign fill_pc_o   = pc_q;
    assign fill_inst_o = mem_rdata_i;

    assign deliver = !restart_i && fetch_en_i && (state_q == LOOKUP) &&
                     cache_hit_i && (out_cnt_q != '0);
    assign miss    = !restart_i && fetch_en_i && (state_q == LOOKUP) && !cache_hit_i;

    // A stale response still in flight blocks the next request
    assign mem_req_o = !restart_i && fetch_en_i && (state_q == MISS_REQ) &&
                       (mem_cnt_q != '0) && !pending_q;

    // Responses seen outside MISS_WAIT belong to an abandoned address
    assign fill_we_o = (state_q == MISS_WAIT) && mem_rvalid_i;

    always_comb begin
        state_d = state_q;
        if (restart_i) begin
            state_d = fetch_en_i ? LOOKUP : IDLE;
        end else begin
            case (state_q)
                IDLE: begin
                    if (fetch_en_i) begin
                        state_d = LOOKUP;
                    end
                end
                LOOKUP: begin
                    if (!fetch_en_i) begin
                        state_d = IDLE;
                    end else if (!cache_hit_i) begin
                        state_d = MISS_REQ;
                    end
                end
                MISS_REQ: begin
                    if (!fetch_en_i) begin
                        state_d = IDLE;
                    end else if (mem_req_o) begin
                        state_d = MISS_WAIT;
                    end
                end
                MISS_WAIT: begin
                    if (mem_rvalid_i) begin
                        state_d = LOOKUP;
                    end
                end
                default: begin
                    state_d = IDLE;
                end
            endcase
        end
    end

    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            state_q      <= IDLE;
            pc_q         <= '0;
            out_cnt_q    <= OUT_CNT_W'(OUT_CREDITS);
            mem_cnt_q    <= MEM_CNT_W'(MEM_CREDITS);
            pending_q    <= 1'b0;
            refill_q     <= 1'b0;
            inst_valid_o <= 1'b0;
            hit_evt_o    <= 1'b0;
            miss_evt_o   <= 1'b0;
        end else begin
            state_q      <= state_d;
            inst_valid_o <= deliver;
            // A word that was just refilled counts as the miss only
            hit_evt_o    <= deliver && !refill_q;
            miss_evt_o   <= miss;
            out_cnt_q    <= out_cnt_q - OUT_CNT_W'(deliver) + OUT_CNT_W'(out_credit_i);
            mem_cnt_q    <= mem_cnt_q - MEM_CNT_W'(mem_req_o) + MEM_CNT_W'(mem_credit_i);

            if (mem_req_o) begin
                pending_q <= 1'b1;
            end else if (mem_rvalid_i) begin
                pending_q <= 1'b0;
            end

            if (restart_i) begin
                pc_q     <= start_pc_i;
                refill_q <= 1'b0;
            end else if (deliver) begin
                pc_q     <= pc_q + 1'b1;
                refill_q <= 1'b0;
            end else if (fill_we_o) begin
                refill_q <= 1'b1;
            end
        end
    end

    always_ff @(posedge clk_i) begin
        if (deliver) begin
            inst_o    <= cache_inst_i;
            inst_pc_o <= pc_q;
        end
    end

    // A send or request without a credit would wrap its counter above the initial value
    a_credit_bound: assert property (
        @(posedge clk_i) disable iff (rst_i)
        (out_cnt_q <= OUT_CREDITS) && (mem_cnt_q <= MEM_CREDITS)
    );

endmodule

//--- ifetch_pkg.sv
package ifetch_pkg;

    // Cache geometry
    localparam int TAG_W     = 10;
    localparam int INDEX_W   = 7;
    localparam int BLOCK_NUM = 128;

    // Credits held after reset
    localparam int OUT_CREDITS = 4;
    localparam int MEM_CREDITS = 2;

    // Credit counter widths, wide enough for the full credit count
    localparam int OUT_CNT_W = $clog2(OUT_CREDITS + 1);
    localparam int MEM_CNT_W = $clog2(MEM_CREDITS + 1);

    // Register numbers
    localparam logic [1:0] CSR_CTRL   = 2'd0;
    localparam logic [1:0] CSR_START  = 2'd1;
    localparam logic [1:0] CSR_HITS   = 2'd2;
    localparam logic [1:0] CSR_MISSES = 2'd3;

    // Word address, tag in the upper bits and line index in the lower bits
    typedef logic [TAG_W+INDEX_W-1:0] inst_addr_t;
    typedef logic [TAG_W-1:0]         cache_tag_t;
    typedef logic [INDEX_W-1:0]       cache_index_t;

    typedef logic [31:0] inst_t;
    typedef logic [31:0] cnt_t;
    typedef logic [1:0]  csr_addr_t;

    typedef enum logic [1:0] {
        IDLE,
        LOOKUP,
        MISS_REQ,
        MISS_WAIT
    } fetch_state_t;

endpackage

//--- ifetch_top.f
ifetch_pkg.sv
inst_cache.sv
fetch_ctrl.sv
fetch_csr.sv
ifetch_top.sv
tb_mem_model.sv
tb_ifetch_top.sv

//--- ifetch_top.sv
`timescale 1ns/1ps

module ifetch_top import ifetch_pkg::*; (
    input  logic        clk_i,
    input  logic        rst_i,
    input  logic        cfg_we_i,
    input  csr_addr_t   cfg_addr_i,
    input  logic [31:0] cfg_wdata_i,
    output logic [31:0] cfg_rdata_o,
    output logic        inst_valid_o,
    output inst_t       inst_o,
    output inst_addr_t  inst_pc_o,
    input  logic        out_credit_i,
    output logic        mem_req_o,
    output inst_addr_t  mem_addr_o,
    input  logic        mem_credit_i,
    input  logic        mem_rvalid_i,
    input  inst_t       mem_rdata_i
);

    logic       fetch_en;
    logic       restart;
    inst_addr_t start_pc;
    logic       flush;
    logic       hit_evt;
    logic       miss_evt;
    inst_addr_t lookup_pc;
    logic       fill_we;
    inst_addr_t fill_pc;
    inst_t      fill_inst;
    logic       cache_hit;
    inst_t      cache_inst;

    fetch_csr fetch_csr_i (
        .clk_i       (clk_i),
        .rst_i       (rst_i),
        .cfg_we_i    (cfg_we_i),
        .cfg_addr_i  (cfg_addr_i),
        .cfg_wdata_i (cfg_wdata_i),
        .cfg_rdata_o (cfg_rdata_o),
        .hit_evt_i   (hit_evt),
        .miss_evt_i  (miss_evt),
        .fetch_en_o  (fetch_en),
        .restart_o   (restart),
        .start_pc_o  (start_pc),
        .flush_o     (flush)
    );

    fetch_ctrl fetch_ctrl_i (
        .clk_i        (clk_i),
        .rst_i        (rst_i),
        .fetch_en_i   (fetch_en),
        .restart_i    (restart),
        .start_pc_i   (start_pc),
        .cache_hit_i  (cache_hit),
        .cache_inst_i (cache_inst),
        .lookup_pc_o  (lookup_pc),
        .fill_we_o    (fill_we),
        .fill_pc_o    (fill_pc),
        .fill_inst_o  (fill_inst),
        .mem_req_o    (mem_req_o),
        .mem_addr_o   (mem_addr_o),
        .mem_credit_i (mem_credit_i),
        .mem_rvalid_i (mem_rvalid_i),
        .mem_rdata_i  (mem_rdata_i),
        .out_credit_i (out_credit_i),
        .inst_valid_o (inst_valid_o),
        .inst_o       (inst_o),
        .inst_pc_o    (inst_pc_o),
        .hit_evt_o    (hit_evt),
        .miss_evt_o   (miss_evt)
    );

    inst_cache inst_cache_i (
        .clk_i       (clk_i),
        .rst_i       (rst_i),
        .flush_i     (flush),
        .lookup_pc_i (lookup_pc),
        .fill_we_i   (fill_we),
        .fill_pc_i   (fill_pc),
        .fill_inst_i (fill_inst),
        .hit_o       (cache_hit),
        .inst_o      (cache_inst)
    );

endmodule

//--- inst_cache.sv
`timescale 1ns/1ps

module inst_cache import ifetch_pkg::*; (
    input  logic       clk_i,
    input  logic       rst_i,
    input  logic       flush_i,
    input  inst_addr_t lookup_pc_i,
    input  logic       fill_we_i,
    input  inst_addr_t fill_pc_i,
    input  inst_t      fill_inst_i,
    output logic       hit_o,
    output inst_t      inst_o
);

    inst_t          data_q [BLOCK_NUM];
    cache_tag_t     tag_q  [BLOCK_NUM];
    logic [BLOCK_NUM-1:0] valid_q;

    cache_index_t   rd_index;
    cache_tag_t     rd_tag;
    cache_index_t   wr_index;
    cache_tag_t     wr_tag;
    logic           bypass;
    logic           array_hit;

    assign rd_index = lookup_pc_i[INDEX_W-1:0];
    assign rd_tag   = lookup_pc_i[INDEX_W +: TAG_W];
    assign wr_index = fill_pc_i[INDEX_W-1:0];
    assign wr_tag   = fill_pc_i[INDEX_W +: TAG_W];

    // Bypass needs the full address, an index match alone could hand back another tag's word
    assign bypass    = fill_we_i && (fill_pc_i == lookup_pc_i);
    assign array_hit = valid_q[rd_index] && (tag_q[rd_index] == rd_tag);

    assign hit_o  = bypass || array_hit;
    assign inst_o = bypass ? fill_inst_i : data_q[rd_index];

    always_ff @(posedge clk_i) begin
        if (rst_i || flush_i) begin
            valid_q <= '0;
        end else if (fill_we_i) begin
            valid_q[wr_index] <= 1'b1;
        end
    end

    always_ff @(posedge clk_i) begin
        if (fill_we_i) begin
            tag_q[wr_index]  <= wr_tag;
            data_q[wr_index] <= fill_inst_i;
        end
    end

    // Fill strobe comes from the fetch FSM and must always be resolved
    a_fill_we_known: assert property (
        @(posedge clk_i) disable iff (rst_i)
        !$isunknown(fill_we_i)
    );

endmodule

//--- tb_ifetch_top.sv
`timescale 1ns/1ps

module tb_ifetch_top import ifetch_pkg::*; ();

    localparam inst_addr_t RANGE_A = 17'h00040;
    localparam inst_addr_t RANGE_B = 17'h00440;
    localparam inst_addr_t RANGE_C = 17'h10000;

    logic        clk_i;
    logic        rst_i;
    logic        cfg_we;
    csr_addr_t   cfg_addr;
    logic [31:0] cfg_wdata;
    logic [31:0] cfg_rdata;
    logic        inst_valid;
    inst_t       inst;
    inst_addr_t  inst_pc;
    logic        out_credit;
    logic        mem_req;
    inst_addr_t  mem_addr;
    logic        mem_credit;
    logic        mem_rvalid;
    inst_t       mem_rdata;
    inst_addr_t  resp_addr;
    logic        mem_busy;
    logic [31:0] mem_err;
    logic        mem_hold;
    logic [31:0] rng_q = 32'h33bb_f9b0;

    logic       cons_hold;
    logic       cons_random;
    inst_addr_t exp_pc;
    int got_cnt;
    int req_total;
    int req_base;
    int taken_total;
    int returned_total;
    int allow_total;
    int err_cnt;
    int check_cnt;
    int test_num;
    int test_err_base;
    bit timed_out;

    function automatic logic [31:0] xorshift32(input logic [31:0] s);
        logic [31:0] x;
        x = s;
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    // Memory contents: address mixed with a constant, rotated left by the low address bits
    function automatic inst_t mem_word(input inst_addr_t a);
        logic [31:0] v;
        logic [63:0] w;
        v = {15'd0, a} ^ 32'h5a3c_96e1;
        w = {v, v} << a[4:0];
        return w[63:32];
    endfunction

    assign mem_rdata = mem_word(resp_addr);

    ifetch_top ifetch_top_i (
        .clk_i        (clk_i),
        .rst_i        (rst_i),
        .cfg_we_i     (cfg_we),
        .cfg_addr_i   (cfg_addr),
        .cfg_wdata_i  (cfg_wdata),
        .cfg_rdata_o  (cfg_rdata),
        .inst_valid_o (inst_valid),
        .inst_o       (inst),
        .inst_pc_o    (inst_pc),
        .out_credit_i (out_credit),
        .mem_req_o    (mem_req),
        .mem_addr_o   (mem_addr),
        .mem_credit_i (mem_credit),
        .mem_rvalid_i (mem_rvalid),
        .mem_rdata_i  (mem_rdata)
    );

    tb_mem_model mem_model_i (
        .clk_i       (clk_i),
        .rst_i       (rst_i),
        .req_i       (mem_req),
        .addr_i      (mem_addr),
        .delay_i     (rng_q[2:0]),
        .hold_i      (mem_hold),
        .credit_o    (mem_credit),
        .rvalid_o    (mem_rvalid),
        .resp_addr_o (resp_addr),
        .busy_o      (mem_busy),
        .err_cnt_o   (mem_err)
    );

    initial begin
        clk_i = 1'b0;
        forever #4 clk_i = ~clk_i;
    end

    always @(posedge clk_i) begin
        rng_q <= xorshift32(rng_q);
    end

    // Consumer returns one credit per instruction, capped so each run stops at its length
    always @(posedge clk_i) begin : consumer
        logic give;
        if (rst_i) begin
            out_credit     <= 1'b0;
            taken_total    <= 0;
            returned_total <= 0;
        end else begin
            if (inst_valid) begin
                taken_total <= taken_total + 1;
            end
            give = (taken_total > returned_total) &&
                   (returned_total + OUT_CREDITS < allow_total);
            if (cons_hold) begin
                give = 1'b0;
            end else if (cons_random) begin
                give = give && rng_q[9];
            end
            out_credit <= give;
            if (give) begin
                returned_total <= returned_total + 1;
            end
        end
    end

    always @(posedge clk_i) begin
        if (!rst_i) begin
            if (mem_req) begin
                req_total <= req_total + 1;
                check_cnt = check_cnt + 1;
                // Fetch only moves on by delivering, so a miss is for the next expected address
                if (mem_addr !== exp_pc) begin
                    $display("Mismatch at %0t: mem_addr_o is %h, expected %h",
                             $time, mem_addr, exp_pc);
                    err_cnt = err_cnt + 1;
                end
            end
            if (inst_valid) begin
                check_cnt = check_cnt + 2;
                if (inst_pc !== exp_pc) begin
                    $display("Mismatch at %0t: inst_pc_o is %h, expected %h",
                             $time, inst_pc, exp_pc);
                    err_cnt = err_cnt + 1;
                end
                if (inst !== mem_word(inst_pc)) begin
                    $display("Mismatch at %0t: inst_o is %h for address %h, expected %h",
                             $time, inst, inst_pc, mem_word(inst_pc));
                    err_cnt = err_cnt + 1;
                end
                exp_pc = exp_pc + 1'b1;
                got_cnt <= got_cnt + 1;
            end
        end
    end

    task automatic cfg_write(input csr_addr_t a, input logic [31:0] d);
        @(posedge clk_i);
        cfg_we    <= 1'b1;
        cfg_addr  <= a;
        cfg_wdata <= d;
        @(posedge clk_i);
        cfg_we <= 1'b0;
    endtask

    task automatic cfg_read(input csr_addr_t a, output logic [31:0] d);
        @(posedge clk_i);
        cfg_addr <= a;
        @(posedge clk_i);
        d = cfg_rdata;
    endtask

    task automatic check_value(input string what, input int got, input int exp);
        check_cnt = check_cnt + 1;
        if (got != exp) begin
            $display("Mismatch at %0t: %s is %0d, expected %0d", $time, what, got, exp);
            err_cnt = err_cnt + 1;
        end
    endtask

    // Stop fetch, let the memory drain and collect all consumer credits back
    task automatic prepare_run(input inst_addr_t start, input int n);
        int cycles;
        cfg_write(CSR_CTRL, 32'd0);
        cycles = 0;
        @(posedge clk_i);
        while (!timed_out && mem_busy) begin
            @(posedge clk_i);
            cycles = cycles + 1;
            if (cycles > 100) begin
                $display("Timeout: memory stayed busy after fetch was stopped");
                timed_out = 1'b1;
            end
        end
        // New limit lets the last run's credits return and ends this run after n words
        allow_total <= allow_total + n;
        cycles = 0;
        while (!timed_out && returned_total != taken_total) begin
            @(posedge clk_i);
            cycles = cycles + 1;
            if (cycles > 100) begin
                $display("Timeout: consumer credits did not return before the run");
                timed_out = 1'b1;
            end
        end
        exp_pc   = start;
        got_cnt  = 0;
        req_base = req_total;
        cfg_write(CSR_HITS, 32'd0);
        cfg_write(CSR_MISSES, 32'd0);
        cfg_write(CSR_START, 32'(start));
    endtask

    task automatic wait_for(input int n, output int misses, output int reqs);
        int cycles;
        cycles = 0;
        misses = 0;
        reqs   = 0;
        @(posedge clk_i);
        cfg_addr <= CSR_MISSES;
        while (!timed_out) begin
            @(posedge clk_i);
            if (got_cnt >= n) begin
                misses = cfg_rdata;
                reqs   = req_total - req_base;
                break;
            end
            cycles = cycles + 1;
            if (cycles > 3000) begin
                $display("Timeout: only %0d of %0d instructions arrived", got_cnt, n);
                timed_out = 1'b1;
            end
        end
    endtask

    task automatic observe(input int cycles, input int limit);
        for (int i = 0; i < cycles; i++) begin
            @(posedge clk_i);
            if (got_cnt > limit) begin
                $display("Mismatch at %0t: %0d instructions arrived, at most %0d allowed",
                         $time, got_cnt, limit);
                err_cnt = err_cnt + 1;
            end
        end
        check_cnt = check_cnt + 1;
    endtask

    task automatic report_test(input string name);
        test_num = test_num + 1;
        $display("Test %0d %s finished with %0d errors", test_num, name,
                 err_cnt - test_err_base);
        test_err_base = err_cnt;
    endtask

    initial begin : main
        int misses;
        int reqs;
        logic [31:0] d;
        rst_i = 1'b1;
        cfg_we = 1'b0;
        cfg_addr = CSR_CTRL;
        cfg_wdata = '0;
        out_credit = 1'b0;
        mem_hold = 1'b0;
        cons_hold = 1'b0;
        cons_random = 1'b0;
        exp_pc = '0;
        got_cnt = 0;
        req_total = 0;
        req_base = 0;
        allow_total = 0;
        err_cnt = 0;
        check_cnt = 0;
        test_num = 0;
        test_err_base = 0;
        timed_out = 1'b0;
        repeat (2) @(posedge clk_i);
        rst_i <= 1'b0;

        prepare_run(RANGE_A, 64);
        cfg_write(CSR_CTRL, 32'd1);
        wait_for(64, misses, reqs);
        check_value("cold misses", misses, 64);
        cfg_read(CSR_HITS, d);
        check_value("cold hits", d, 0);
        report_test("cold sequential fetch");

        prepare_run(RANGE_A, 64);
        cfg_write(CSR_CTRL, 32'd1);
        wait_for(64, misses, reqs);
        check_value("warm misses", misses, 0);
        check_value("warm memory requests", reqs, 0);
        cfg_read(CSR_HITS, d);
        check_value("warm hits", d, 64);
        report_test("warm refetch");

        cfg_write(CSR_CTRL, 32'd2);
        prepare_run(RANGE_A, 64);
        cfg_write(CSR_CTRL, 32'd1);
        wait_for(64, misses, reqs);
        check_value("misses after flush", misses, 64);
        report_test("flush");

        prepare_run(RANGE_A, 32);
        cons_hold <= 1'b1;
        cfg_write(CSR_CTRL, 32'd1);
        wait_for(OUT_CREDITS, misses, reqs);
        observe(24, OUT_CREDITS);
        cons_hold   <= 1'b0;
        cons_random <= 1'b1;
        wait_for(32, misses, reqs);
        cons_random <= 1'b0;
        report_test("consumer back-pressure");

        prepare_run(RANGE_C, 16);
        mem_hold <= 1'b1;
        cfg_write(CSR_CTRL, 32'd1);
        wait_for(MEM_CREDITS, misses, reqs);
        observe(24, MEM_CREDITS);
        mem_hold <= 1'b0;
        wait_for(16, misses, reqs);
        check_value("cold misses with withheld credits", misses, 16);
        report_test("memory credits");

        prepare_run(RANGE_B, 16);
        cfg_write(CSR_CTRL, 32'd1);
        wait_for(16, misses, reqs);
        check_value("aliased range misses", misses, 16);
        prepare_run(RANGE_A, 16);
        cfg_write(CSR_CTRL, 32'd1);
        wait_for(16, misses, reqs);
        check_value("evicted range misses", misses, 16);
        report_test("tag aliasing");

        if (mem_err != 0) begin
            $display("Memory model saw %0d protocol errors", mem_err);
            err_cnt = err_cnt + 1;
        end
        $display("%0d tests, %0d checks, %0d errors", test_num, check_cnt, err_cnt);
        if (err_cnt == 0 && !timed_out) begin
            $display("** PASS **");
        end else begin
            $display("** FAIL **");
        end
        $finish;
    end

endmodule

//--- tb_mem_model.sv
`timescale 1ns/1ps

module tb_mem_model import ifetch_pkg::*; (
    input  logic        clk_i,
    input  logic        rst_i,
    input  logic        req_i,
    input  inst_addr_t  addr_i,
    input  logic [2:0]  delay_i,
    input  logic        hold_i,
    output logic        credit_o,
    output logic        rvalid_o,
    output inst_addr_t  resp_addr_o,
    output logic        busy_o,
    output logic [31:0] err_cnt_o
);

    logic [2:0] wait_q;
    inst_addr_t addr_q;
    int         dut_credits;
    int         freed;

    initial begin
        credit_o    = 1'b0;
        rvalid_o    = 1'b0;
        resp_addr_o = '0;
        busy_o      = 1'b0;
        err_cnt_o   = '0;
    end

    always @(posedge clk_i) begin : model
        int avail;
        int slots;
        int errs;
        if (rst_i) begin
            credit_o    <= 1'b0;
            rvalid_o    <= 1'b0;
            resp_addr_o <= '0;
            busy_o      <= 1'b0;
            err_cnt_o   <= '0;
            wait_q      <= '0;
            addr_q      <= '0;
            dut_credits <= MEM_CREDITS;
            freed       <= 0;
        end else begin
            // Credits held by fetch, counting the pulse it samples at this edge
            avail = dut_credits + (credit_o ? 1 : 0);
            slots = freed;
            errs  = 0;
            rvalid_o <= 1'b0;
            credit_o <= 1'b0;
            if (req_i) begin
                if (dut_credits == 0) begin
                    $display("Memory request at %0t for address %h was made without a credit",
                             $time, addr_i);
                    errs = errs + 1;
                end else begin
                    avail = avail - 1;
                end
                if (busy_o) begin
                    $display("Second memory request at %0t while one is still outstanding",
                             $time);
                    errs = errs + 1;
                end
                busy_o <= 1'b1;
                wait_q <= delay_i;
                addr_q <= addr_i;
            end else if (busy_o) begin
                if (wait_q == 3'd0) begin
                    rvalid_o    <= 1'b1;
                    resp_addr_o <= addr_q;
                    busy_o      <= 1'b0;
                    slots = slots + 1;
                end else begin
                    wait_q <= wait_q - 3'd1;
                end
            end
            // Withheld credits go back one per cycle once the hold ends
            if (!hold_i && slots > 0) begin
                credit_o <= 1'b1;
                slots = slots - 1;
            end
            dut_credits <= avail;
            freed       <= slots;
            err_cnt_o   <= err_cnt_o + errs;
        end
    end

endmodule
